/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - common/mem_bus_if.sv
      - verilog/shared_memory.sv
      - pipeline/fetch_stage.sv
      - pipeline/decode_stage.sv
      - pipeline/execute_stage.sv
      - pipeline/mem_stage.sv
      - verilog/rv_core_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/rv_core_checker.sv
      - tests/rv_core_tb.sv

/* common/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path and address width
`define XLEN 32

// Unified memory depth in words, indexed by address bits 9..2
`define MEM_WORDS 256

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

/* common/cpu_pkg.sv */
`include "cpu_consts.svh"

package cpu_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    alu_src_imm;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
    } if_id_t;

    typedef struct packed {
        logic             valid;
        ctrl_t            ctrl;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] imm;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic [`XLEN-1:0] rs1_val;
        logic [`XLEN-1:0] rs2_val;
    } id_ex_t;

    // Control bits here are already qualified by valid
    typedef struct packed {
        logic             valid;
        logic             reg_write;
        logic             mem_read;
        logic             mem_write;
        logic [`XLEN-1:0] alu_result;
        logic [`XLEN-1:0] store_data;
        logic [4:0]       rd;
    } ex_mem_t;

    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } wb_t;

endpackage

/* common/mem_bus_if.sv */
`include "cpu_consts.svh"

interface mem_bus_if;

    logic             req;
    logic             we;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
    logic [`XLEN-1:0] rdata;
    logic             gnt;

    modport master (
        output req, we, addr, wdata,
        input  rdata, gnt
    );

    // gnt and rdata come back in the same cycle as req
    modport slave (
        input  req, we, addr, wdata,
        output rdata, gnt
    );

endinterface

/* pipeline/decode_stage.sv */
`include "cpu_consts.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  if_id_t if_id,
    input  logic   branch_taken,
    input  wb_t    wb,
    output logic   stall,
    output id_ex_t id_ex
);
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    ctrl_t            ctrl;
    logic             legal;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] regs [32];

    assign opcode = if_id.instr[6:0];
    assign funct3 = if_id.instr[14:12];
    assign funct7 = if_id.instr[31:25];
    assign rs1    = if_id.instr[19:15];
    assign rs2    = if_id.instr[24:20];
    assign rd     = if_id.instr[11:7];

    // Anything outside the subset leaves legal low and becomes a bubble
    always_comb begin
        ctrl  = '0;
        legal = 1'b0;
        case (opcode)
            OP_REG: begin
                legal          = 1'b1;
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl.alu_op = ALU_ADD;
                    10'b0100000_000: ctrl.alu_op = ALU_SUB;
                    10'b0000000_111: ctrl.alu_op = ALU_AND;
                    10'b0000000_110: ctrl.alu_op = ALU_OR;
                    10'b0000000_100: ctrl.alu_op = ALU_XOR;
                    10'b0000000_010: ctrl.alu_op = ALU_SLT;
                    default:         legal       = 1'b0;
                endcase
            end
            OP_IMM: begin
                legal            = (funct3 == 3'b000);
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_LOAD: begin
                legal            = (funct3 == 3'b010);
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_STORE: begin
                legal            = (funct3 == 3'b010);
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_BRANCH: begin
                legal          = (funct3 == 3'b000) || (funct3 == 3'b001);
                ctrl.branch_eq = (funct3 == 3'b000);
                ctrl.branch_ne = (funct3 == 3'b001);
            end
            default: ;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_STORE:  imm = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
            OP_BRANCH: imm = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
                              if_id.instr[30:25], if_id.instr[11:8], 1'b0};
            default:   imm = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
        endcase
    end

    // Register file, x0 is never written
    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle writeback bypass
    assign rs1_val = (rs1 == 5'd0) ? '0 : (wb.valid && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : (wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

    // Load in ID/EX feeding the instruction behind it
    assign stall = if_id.valid && id_ex.valid && id_ex.ctrl.mem_read &&
                   (id_ex.rd != 5'd0) && (id_ex.rd == rs1 || id_ex.rd == rs2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end else begin
            if (branch_taken || stall || !(if_id.valid && legal)) begin
                id_ex.valid <= 1'b0;
                id_ex.ctrl  <= '0;
            end else begin
                id_ex.valid <= 1'b1;
                id_ex.ctrl  <= ctrl;
            end
            id_ex.pc      <= if_id.pc;
            id_ex.imm     <= imm;
            id_ex.rs1     <= rs1;
            id_ex.rs2     <= rs2;
            id_ex.rd      <= rd;
            id_ex.rs1_val <= rs1_val;
            id_ex.rs2_val <= rs2_val;
        end
    end

endmodule

/* pipeline/execute_stage.sv */
`include "cpu_consts.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  id_ex_t           id_ex,
    input  wb_t              wb,
    output logic             branch_taken,
    output logic [`XLEN-1:0] branch_target,
    output ex_mem_t          ex_mem
);
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] fwd_b;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;

    // EX/MEM is the newer producer, so it is checked first
    function automatic logic [`XLEN-1:0] forward(
        input logic [4:0]       rs,
        input logic [`XLEN-1:0] rf_val,
        input ex_mem_t          mem_q,
        input wb_t              wb_q
    );
        if (rs != 5'd0 && mem_q.reg_write && mem_q.rd == rs) begin
            return mem_q.alu_result;
        end
        if (rs != 5'd0 && wb_q.valid && wb_q.rd == rs) begin
            return wb_q.data;
        end
        return rf_val;
    endfunction

    assign op_a  = forward(id_ex.rs1, id_ex.rs1_val, ex_mem, wb);
    assign fwd_b = forward(id_ex.rs2, id_ex.rs2_val, ex_mem, wb);
    assign op_b  = id_ex.ctrl.alu_src_imm ? id_ex.imm : fwd_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_result = op_a + op_b;
        endcase
    end

    // Resolved here, two younger instructions get squashed
    assign branch_taken  = id_ex.valid &&
                           ((id_ex.ctrl.branch_eq && op_a == fwd_b) ||
                            (id_ex.ctrl.branch_ne && op_a != fwd_b));
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem.valid     <= 1'b0;
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.reg_write  <= id_ex.valid && id_ex.ctrl.reg_write;
            ex_mem.mem_read   <= id_ex.valid && id_ex.ctrl.mem_read;
            ex_mem.mem_write  <= id_ex.valid && id_ex.ctrl.mem_write;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= fwd_b;
            ex_mem.rd         <= id_ex.rd;
        end
    end

endmodule

/* pipeline/fetch_stage.sv */
`include "cpu_consts.svh"

module fetch_stage
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetch_en,
    input  logic             stall,
    input  logic             branch_taken,
    input  logic [`XLEN-1:0] branch_target,
    mem_bus_if.master        ibus,
    output if_id_t           if_id
);
    logic [`XLEN-1:0] pc;

    assign ibus.req   = fetch_en && !stall;
    assign ibus.we    = 1'b0;
    assign ibus.addr  = pc;
    assign ibus.wdata = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= `RESET_PC;
            if_id.valid <= 1'b0;
        end else if (branch_taken) begin
            // Redirect wins, wrong-path word is dropped
            pc          <= branch_target;
            if_id.valid <= 1'b0;
            if_id.instr <= `NOP_INSTR;
        end else if (!stall) begin
            if (ibus.gnt) begin
                pc          <= pc + `XLEN'd4;
                if_id.valid <= 1'b1;
                if_id.pc    <= pc;
                if_id.instr <= ibus.rdata;
            end else begin
                if_id.valid <= 1'b0;
                if_id.instr <= `NOP_INSTR;
            end
        end
    end

endmodule

/* pipeline/mem_stage.sv */
`include "cpu_consts.svh"

module mem_stage
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  ex_mem_t   ex_mem,
    mem_bus_if.master dbus,
    output wb_t       wb
);
    logic mem_access;

    // Data bus outranks fetch, so an access is served in its own cycle
    assign mem_access = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    assign dbus.req   = mem_access;
    assign dbus.we    = ex_mem.mem_write;
    assign dbus.addr  = ex_mem.alu_result;
    assign dbus.wdata = ex_mem.store_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            // Writes to x0 never retire
            wb.valid <= ex_mem.valid && ex_mem.reg_write && (ex_mem.rd != 5'd0);
            wb.rd    <= ex_mem.rd;
            if (ex_mem.mem_read) begin
                wb.data <= dbus.rdata;
            end else begin
                wb.data <= ex_mem.alu_result;
            end
        end
    end

endmodule

/* project.f */
+incdir+common
common/cpu_pkg.sv
common/mem_bus_if.sv
verilog/shared_memory.sv
pipeline/fetch_stage.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
pipeline/mem_stage.sv
verilog/rv_core_top.sv
tests/rv_core_checker.sv
tests/rv_core_tb.sv

/* tests/rv_core_checker.sv */
module rv_core_checker (
    input logic       clk,
    input logic       rst_n,
    input logic       ibus_req,
    input logic       ibus_gnt,
    input logic       dbus_req,
    input logic       dbus_gnt,
    input logic       retire_valid,
    input logic [4:0] retire_rd
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // Arbiter serves one master per cycle
    a_single_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        !(ibus_gnt && dbus_gnt))
    else begin
        $error("ibus and dbus granted in the same cycle");
        fail_count++;
    end

    // x0 writes must never reach the port
    a_retire_rd: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> retire_rd != 5'd0)
    else begin
        $error("retirement reported for x0");
        fail_count++;
    end

    a_ibus_gnt_req: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_gnt |-> ibus_req)
    else begin
        $error("ibus grant without a request");
        fail_count++;
    end

    a_dbus_gnt_req: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_gnt |-> dbus_req)
    else begin
        $error("dbus grant without a request");
        fail_count++;
    end

endmodule

bind rv_core_top rv_core_checker i_rv_core_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .ibus_req     (ibus.req),
    .ibus_gnt     (ibus.gnt),
    .dbus_req     (dbus.req),
    .dbus_gnt     (dbus.gnt),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd)
);

/* tests/rv_core_stimulus.txt */
# P <word index, decimal> <instruction, hex> [assembly]: program word for the load port
# E <rd, decimal> <value, hex> [note]: expected retirement, in retirement order
P 0  00500093  addi x1, x0, 5
P 1  ffd00113  addi x2, x0, -3
P 2  002081b3  add  x3, x1, x2
P 3  40208233  sub  x4, x1, x2
P 4  0020f2b3  and  x5, x1, x2
P 5  0020e333  or   x6, x1, x2
P 6  0020c3b3  xor  x7, x1, x2
P 7  00112433  slt  x8, x2, x1
P 8  0020a4b3  slt  x9, x1, x2
P 9  00118513  addi x10, x3, 1
P 10 00a50533  add  x10, x10, x10
P 11 003505b3  add  x11, x10, x3
P 12 00708013  addi x0, x1, 7
P 13 00100633  add  x12, x0, x1
P 14 10b02023  sw   x11, 256(x0)
P 15 10002683  lw   x13, 256(x0)
P 16 00168733  add  x14, x13, x1
P 17 00c08663  beq  x1, x12, +12
P 18 06300793  addi x15, x0, 99
P 19 06200813  addi x16, x0, 98
P 20 00c09463  bne  x1, x12, +8
P 21 02a00893  addi x17, x0, 42
P 22 00000063  beq  x0, x0, 0
E 1  00000005
E 2  fffffffd
E 3  00000002
E 4  00000008
E 5  00000005
E 6  fffffffd
E 7  fffffff8
E 8  00000001  negative operand is less
E 9  00000000
E 10 00000003
E 10 00000006
E 11 00000008
E 12 00000005  x0 write skipped
E 13 00000008  loaded back from 0x100
E 14 0000000d  load-use stall
E 17 0000002a  after the not-taken bne

/* tests/rv_core_tb.sv */
module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam string STIM_FILE = "tests/rv_core_stimulus.txt";

    logic        clk;
    logic        rst_n;
    logic        fetch_en;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    // Program image and expected retirements from the stimulus file
    logic [31:0] prog_idx [$];
    logic [31:0] prog_word [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];

    int unsigned errors;
    int unsigned retired;
    int unsigned asrt_fails;
    int unsigned wd_cycles;
    logic        cfg_ready;

    rv_core_top i_rv_core_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_en     (fetch_en),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic read_stimulus();
        int          fd;
        int          fields;
        string       line;
        byte         tag;
        int unsigned num;
        logic [31:0] word;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines yield fewer than three fields
            fields = $sscanf(line, "%c %d %h", tag, num, word);
            if (fields == 3 && tag == "P") begin
                prog_idx.push_back(num);
                prog_word.push_back(word);
            end else if (fields == 3 && tag == "E") begin
                exp_rd.push_back(num[4:0]);
                exp_data.push_back(word);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_retirement();
        assert (retired < exp_rd.size())
        else begin
            $display("Unexpected retirement of x%0d at time %0t after the last expected one",
                     retire_rd, $time);
            errors++;
        end
        if (retired < exp_rd.size()) begin
            assert (retire_rd === exp_rd[retired])
            else begin
                $display("Fail: time %0t, retire_rd = %0d, expected %0d",
                         $time, retire_rd, exp_rd[retired]);
                errors++;
            end
            assert (retire_data === exp_data[retired])
            else begin
                $display("Fail: time %0t, retire_data = %h, expected %h",
                         $time, retire_data, exp_data[retired]);
                errors++;
            end
        end
        retired++;
    endtask

    initial begin
        rst_n     = 1'b0;
        fetch_en  = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        errors    = 0;
        retired   = 0;
        cfg_ready = 1'b0;
        read_stimulus();
        wd_cycles = 20 * prog_word.size() + 40 * exp_rd.size();
        cfg_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // Program goes in through the load port while fetch is off
        foreach (prog_word[i]) begin
            @(posedge clk);
            #1;
            load_en   = 1'b1;
            load_addr = prog_idx[i] << 2;
            load_data = prog_word[i];
        end
        @(posedge clk);
        #1;
        load_en  = 1'b0;
        fetch_en = 1'b1;
    end

    // Retirement outputs settle after the rising edge
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            check_retirement();
        end
    end

    // Watchdog, also the normal end of the run
    initial begin
        wait (cfg_ready);
        repeat (wd_cycles) @(posedge clk);
        assert (retired >= exp_rd.size())
        else begin
            $display("Watchdog expired with %0d of %0d expected retirements seen",
                     retired, exp_rd.size());
            errors++;
        end
        asrt_fails = i_rv_core_top.i_rv_core_checker.fail_count;
        $display("Retirements %0d, errors %0d, assertion failures %0d",
                 retired, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog/rv_core_top.sv */
`include "cpu_consts.svh"

module rv_core_top
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetch_en,
    input  logic             load_en,
    input  logic [`XLEN-1:0] load_addr,
    input  logic [`XLEN-1:0] load_data,
    output logic             retire_valid,
    output logic [4:0]       retire_rd,
    output logic [`XLEN-1:0] retire_data
);
    if_id_t           if_id;
    id_ex_t           id_ex;
    ex_mem_t          ex_mem;
    wb_t              wb;
    logic             stall;
    logic             branch_taken;
    logic [`XLEN-1:0] branch_target;

    mem_bus_if ibus ();
    mem_bus_if dbus ();

    fetch_stage i_fetch_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_en      (fetch_en),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .ibus          (ibus.master),
        .if_id         (if_id)
    );

    decode_stage i_decode_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .if_id        (if_id),
        .branch_taken (branch_taken),
        .wb           (wb),
        .stall        (stall),
        .id_ex        (id_ex)
    );

    execute_stage i_execute_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_ex         (id_ex),
        .wb            (wb),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .ex_mem        (ex_mem)
    );

    mem_stage i_mem_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem),
        .dbus   (dbus.master),
        .wb     (wb)
    );

    shared_memory i_shared_memory (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .ibus      (ibus.slave),
        .dbus      (dbus.slave)
    );

    // Retirement port mirrors MEM/WB
    assign retire_valid = wb.valid;
    assign retire_rd    = wb.rd;
    assign retire_data  = wb.data;

endmodule

/* verilog/shared_memory.sv */
`include "cpu_consts.svh"

module shared_memory (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load_en,
    input  logic [`XLEN-1:0] load_addr,
    input  logic [`XLEN-1:0] load_data,
    mem_bus_if.slave         ibus,
    mem_bus_if.slave         dbus
);
    localparam int IDX_W = $clog2(`MEM_WORDS);

    logic [`XLEN-1:0] mem [`MEM_WORDS];
    logic             wr_en;
    logic [IDX_W-1:0] wr_idx;
    logic [`XLEN-1:0] wr_data;

    // Fixed priority: load port, then data bus, then instruction bus
    assign dbus.gnt = dbus.req && !load_en;
    assign ibus.gnt = ibus.req && !load_en && !dbus.req;

    // Reads are asynchronous from the array
    assign dbus.rdata = mem[dbus.addr[IDX_W+1:2]];
    assign ibus.rdata = mem[ibus.addr[IDX_W+1:2]];

    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = load_addr[IDX_W+1:2];
        wr_data = load_data;
        if (load_en) begin
            wr_en = 1'b1;
        end else if (dbus.gnt && dbus.we) begin
            wr_en   = 1'b1;
            wr_idx  = dbus.addr[IDX_W+1:2];
            wr_data = dbus.wdata;
        end else if (ibus.gnt && ibus.we) begin
            wr_en   = 1'b1;
            wr_idx  = ibus.addr[IDX_W+1:2];
            wr_data = ibus.wdata;
        end
        // No stray stores land while the core sits in reset
        if (!rst_n) begin
            wr_en = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

endmodule
